//--- pipeline_pkg.sv
// lane count, widths, lane and branch record types, commit status codes
package pipeline_pkg;

	////////////////////////////////
	// sizes
	////////////////////////////////

	localparam int ways          = 3;  // lanes per bundle
	localparam int xlen          = 32; // data and address width
	localparam int reg_idx_width = 5;
	localparam int inst_bytes    = 4;  // pc step to the next instruction

	localparam logic [reg_idx_width-1:0] zero_reg = '0; // hardwired zero, never written

	////////////////////////////////
	// lane types
	////////////////////////////////

	typedef logic [1:0] way_t;        // lane index
	typedef logic [ways-1:0] way_mask_t; // one bit per lane
	typedef logic [1:0] rollback_t;   // trailing lanes to squash

	// one instruction as it rides down a lane
	// fetch/decode/alu results already folded in
	typedef struct packed {
		logic                     valid;
		logic [xlen-1:0]          pc;
		logic [reg_idx_width-1:0] dest;
		logic [xlen-1:0]          result;
		logic                     halt;    // wfi seen
		logic                     illegal; // bad encoding
	} slot_t;

	// resolved branch of a bundle, at most one per bundle
	typedef struct packed {
		logic            take;
		logic [xlen-1:0] target;
		way_t            way; // lane holding the branch
	} branch_t;

	////////////////////////////////
	// commit status
	////////////////////////////////

	typedef enum logic [1:0] {
		no_error      = 2'd0,
		halted_on_wfi = 2'd1,
		illegal_inst  = 2'd2
	} exception_t;

endpackage

//--- bundle_register.sv
// stage register of n lanes with a per-lane clear, payload type as a parameter
`timescale 1ns/1ps

module bundle_register #(
	parameter type payload_t = logic,
	parameter int  lanes     = 1
) (
	input  logic             clock,
	input  payload_t         d [lanes],
	input  logic [lanes-1:0] kill, // lane loads zero when set
	output payload_t         q [lanes]
);

	// no enable, the pipe moves every cycle
	always_ff @(posedge clock) begin
		for (int i = 0; i < lanes; i++) begin
			if (kill[i]) begin
				q[i] <= '0; // zero payload reads as an invalid lane
			end else begin
				q[i] <= d[i];
			end
		end
	end

	// a cleared lane must come out empty one cycle later
	for (genvar i = 0; i < lanes; i++) begin : g_kill_check
		assert property (@(posedge clock) kill[i] |=> (q[i] == '0))
			else $error("lane %0d not cleared after kill", i);
	end

endmodule

//--- pipeline_control.sv
// lane kill masks for rollback, branch flush and reset, plus commit count and status
`timescale 1ns/1ps

module pipeline_control (
	input  logic                   clock,
	input  logic                   reset,
	input  pipeline_pkg::rollback_t in_rollback,
	input  pipeline_pkg::branch_t   execute_branch,
	input  logic                   commit_valid [pipeline_pkg::ways],
	input  logic                   commit_halt [pipeline_pkg::ways],
	input  logic                   commit_illegal [pipeline_pkg::ways],
	output pipeline_pkg::way_mask_t issue_kill,
	output pipeline_pkg::way_mask_t execute_kill,
	output pipeline_pkg::way_mask_t writeback_keep,
	output logic [1:0]             completed_insts,
	output pipeline_pkg::exception_t error_status
);

	import pipeline_pkg::*;

	logic flush;       // taken branch sitting in execute
	logic any_halt;    // valid lanes only
	logic any_illegal;

	assign flush = execute_branch.take;

	////////////////////////////////
	// kill and keep masks
	////////////////////////////////

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			// rollback n drops the last n lanes
			issue_kill[i] = !reset || flush || (i >= ways - int'(in_rollback));
			execute_kill[i] = !reset || flush; // younger bundle in issue dies
			// branching bundle keeps lanes up to the branch
			writeback_keep[i] = reset && (!flush || (i <= int'(execute_branch.way)));
		end
	end

	////////////////////////////////
	// commit count and status
	////////////////////////////////

	always_comb begin
		completed_insts = '0;
		any_halt = 1'b0;
		any_illegal = 1'b0;
		for (int i = 0; i < ways; i++) begin
			completed_insts = completed_insts + 2'(commit_valid[i]);
			any_halt = any_halt | (commit_valid[i] & commit_halt[i]);
			any_illegal = any_illegal | (commit_valid[i] & commit_illegal[i]);
		end
	end

	// illegal wins over halt
	assign error_status = any_illegal ? illegal_inst :
	                      any_halt    ? halted_on_wfi :
	                                    no_error;

	// branch way must name a real lane whenever it flushes
	assert property (@(posedge clock) disable iff (!reset)
		flush |-> (execute_branch.way <= way_t'(ways - 1)))
		else $error("flush with branch way %0d", execute_branch.way);

	// keep mask is a run of ones from lane 0
	assert property (@(posedge clock)
		((writeback_keep & (writeback_keep + 1'b1)) == '0))
		else $error("keep mask not contiguous: %b", writeback_keep);

endmodule

//--- writeback_register.sv
// writeback stage register with branch lane truncation and register write commit
`timescale 1ns/1ps

module writeback_register (
	input  logic                   clock,
	input  pipeline_pkg::slot_t     execute_slots [pipeline_pkg::ways],
	input  pipeline_pkg::way_mask_t writeback_keep,
	output logic                   commit_valid [pipeline_pkg::ways],
	output logic                   commit_halt [pipeline_pkg::ways],
	output logic                   commit_illegal [pipeline_pkg::ways],
	output logic                   commit_wr_en [pipeline_pkg::ways],
	output logic [pipeline_pkg::reg_idx_width-1:0] commit_wr_idx [pipeline_pkg::ways],
	output logic [pipeline_pkg::xlen-1:0] commit_wr_data [pipeline_pkg::ways],
	output logic [pipeline_pkg::xlen-1:0] commit_npc [pipeline_pkg::ways]
);

	import pipeline_pkg::*;

	slot_t wb_slot [ways];

	// lanes past the branch come in cleared
	always_ff @(posedge clock) begin
		for (int i = 0; i < ways; i++) begin
			if (writeback_keep[i]) begin
				wb_slot[i] <= execute_slots[i];
			end else begin
				wb_slot[i] <= '0;
			end
		end
	end

	////////////////////////////////
	// commit side
	////////////////////////////////

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			commit_valid[i]   = wb_slot[i].valid;
			commit_halt[i]    = wb_slot[i].halt;
			commit_illegal[i] = wb_slot[i].illegal;
			// r0 stays zero
			commit_wr_en[i]   = wb_slot[i].valid && (wb_slot[i].dest != zero_reg);
			commit_wr_idx[i]  = wb_slot[i].dest;
			commit_wr_data[i] = wb_slot[i].result;
			commit_npc[i]     = wb_slot[i].pc + xlen'(inst_bytes); // sequential next pc
		end
	end

	for (genvar i = 0; i < ways; i++) begin : g_wr_check
		assert property (@(posedge clock) commit_wr_en[i] |-> commit_valid[i])
			else $error("write enable on empty lane %0d", i);
	end

endmodule

//--- bundle_pipeline.sv
// three-lane pipeline top: input bundle packing, issue, execute and writeback stages
`timescale 1ns/1ps

module bundle_pipeline (
	input  logic                   clock,
	input  logic                   reset, // sync, active low
	// input bundle, one entry per lane
	input  logic                   in_valid [pipeline_pkg::ways],
	input  logic [pipeline_pkg::xlen-1:0] in_pc [pipeline_pkg::ways],
	input  logic [pipeline_pkg::reg_idx_width-1:0] in_dest [pipeline_pkg::ways],
	input  logic [pipeline_pkg::xlen-1:0] in_result [pipeline_pkg::ways],
	input  logic                   in_halt [pipeline_pkg::ways],
	input  logic                   in_illegal [pipeline_pkg::ways],
	// per-bundle fields
	input  pipeline_pkg::rollback_t in_rollback,
	input  logic                   in_take_branch,
	input  logic [pipeline_pkg::xlen-1:0] in_branch_target,
	input  pipeline_pkg::way_t      in_branch_way,
	// commit
	output logic                   commit_wr_en [pipeline_pkg::ways],
	output logic [pipeline_pkg::reg_idx_width-1:0] commit_wr_idx [pipeline_pkg::ways],
	output logic [pipeline_pkg::xlen-1:0] commit_wr_data [pipeline_pkg::ways],
	output logic [pipeline_pkg::xlen-1:0] commit_npc [pipeline_pkg::ways],
	output logic [1:0]             completed_insts,
	output pipeline_pkg::exception_t error_status
);

	import pipeline_pkg::*;

	slot_t     in_slot [ways];
	branch_t   in_branch [1];
	slot_t     issue_slot_q [ways];
	branch_t   issue_branch_q [1];
	slot_t     execute_slot_q [ways];
	branch_t   execute_branch_q [1];

	way_mask_t issue_kill;
	way_mask_t execute_kill;
	way_mask_t writeback_keep;

	logic      commit_valid [ways];
	logic      commit_halt [ways];
	logic      commit_illegal [ways];

	////////////////////////////////
	// input packing
	////////////////////////////////

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			in_slot[i] = '{valid: in_valid[i], pc: in_pc[i], dest: in_dest[i],
			               result: in_result[i], halt: in_halt[i], illegal: in_illegal[i]};
		end
		in_branch[0] = '{take: in_take_branch, target: in_branch_target, way: in_branch_way};
	end

	pipeline_control control (
		.clock           (clock),
		.reset           (reset),
		.in_rollback     (in_rollback),
		.execute_branch  (execute_branch_q[0]),
		.commit_valid    (commit_valid),
		.commit_halt     (commit_halt),
		.commit_illegal  (commit_illegal),
		.issue_kill      (issue_kill),
		.execute_kill    (execute_kill),
		.writeback_keep  (writeback_keep),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	////////////////////////////////
	// issue and execute stages
	////////////////////////////////

	bundle_register #(.payload_t(slot_t), .lanes(ways)) issue_slots (
		.clock (clock),
		.d     (in_slot),
		.kill  (issue_kill),
		.q     (issue_slot_q)
	);

	// branch record dies only with the whole bundle
	bundle_register #(.payload_t(branch_t), .lanes(1)) issue_branch (
		.clock (clock),
		.d     (in_branch),
		.kill  (issue_kill[0]),
		.q     (issue_branch_q)
	);

	bundle_register #(.payload_t(slot_t), .lanes(ways)) execute_slots (
		.clock (clock),
		.d     (issue_slot_q),
		.kill  (execute_kill),
		.q     (execute_slot_q)
	);

	bundle_register #(.payload_t(branch_t), .lanes(1)) execute_branch (
		.clock (clock),
		.d     (issue_branch_q),
		.kill  (execute_kill[0]),
		.q     (execute_branch_q)
	);

	// writeback, commit ports are combinational from here
	writeback_register writeback (
		.clock          (clock),
		.execute_slots  (execute_slot_q),
		.writeback_keep (writeback_keep),
		.commit_valid   (commit_valid),
		.commit_halt    (commit_halt),
		.commit_illegal (commit_illegal),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_npc     (commit_npc)
	);

endmodule

//--- bundle_pipeline_model.svh
// commit stream reference model, lcg random source and value check task
`ifndef BUNDLE_PIPELINE_MODEL_SVH
`define BUNDLE_PIPELINE_MODEL_SVH

typedef slot_t [ways-1:0] lanes_t;

lanes_t      expected_q [$];           // one entry per presented bundle
int          flush_left   = 0;         // bundles still to be flushed
int          check_errors = 0;
logic [31:0] lcg_state    = 32'hfeaac96b;

function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
	if (expected !== actual) begin
		$display("FAIL %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		check_errors++;
	end
endtask

// what the bundle should look like at commit
function automatic void push_expected(lanes_t lanes, rollback_t rb, logic take, way_t way);
	lanes_t kept;
	kept = lanes;
	if (flush_left > 0) begin
		kept = '0; // younger than a taken branch
		flush_left--;
	end else begin
		for (int i = 0; i < ways; i++) begin
			if (i + int'(rb) >= ways) kept[i] = '0; // trailing lanes rolled back
		end
		// rollback of 3 takes the branch record with it
		if (take && rb != 2'd3) begin
			for (int i = 0; i < ways; i++) begin
				if (i > int'(way)) kept[i] = '0;
			end
			flush_left = 2;
		end
	end
	expected_q.push_back(kept);
endfunction

task automatic compare_commit();
	lanes_t     want;
	int         count;
	exception_t status;
	logic       wr;
	want = expected_q.pop_front();
	count = 0;
	status = no_error;
	for (int i = 0; i < ways; i++) begin
		wr = want[i].valid && (want[i].dest != zero_reg);
		check_value($sformatf("commit_wr_en[%0d]", i), 32'(wr), 32'(commit_wr_en[i]));
		if (wr) begin
			check_value($sformatf("commit_wr_idx[%0d]", i), 32'(want[i].dest),
				32'(commit_wr_idx[i]));
			check_value($sformatf("commit_wr_data[%0d]", i), want[i].result, commit_wr_data[i]);
		end
		if (want[i].valid) begin
			check_value($sformatf("commit_npc[%0d]", i), want[i].pc + 32'd4, commit_npc[i]);
			count++;
			if (want[i].illegal) status = illegal_inst;
			else if (want[i].halt && status == no_error) status = halted_on_wfi;
		end
	end
	check_value("completed_insts", 32'(count), 32'(completed_insts));
	check_value("error_status", 32'(status), 32'(error_status));
endtask

`endif

//--- bundle_pipeline_tb.sv
// testbench for the three-lane pipeline: clock, reset, random stimulus, scoreboard, timeout
`timescale 1ns/1ps

module bundle_pipeline_tb;

	import pipeline_pkg::*;

	localparam int reset_cycles   = 3;
	localparam int plain_count    = 200;
	localparam int rollback_count = 100;
	localparam int branch_count   = 80;
	localparam int status_count   = 100;
	// reset, quiet check, four random tests with a 3 cycle drain each, margin
	localparam int cycle_limit = reset_cycles + 3 + plain_count + rollback_count
		+ branch_count + status_count + 4 * 3 + 20;

	logic                     clock;
	logic                     reset;
	logic                     in_valid [ways];
	logic [xlen-1:0]          in_pc [ways];
	logic [reg_idx_width-1:0] in_dest [ways];
	logic [xlen-1:0]          in_result [ways];
	logic                     in_halt [ways];
	logic                     in_illegal [ways];
	rollback_t                in_rollback;
	logic                     in_take_branch;
	logic [xlen-1:0]          in_branch_target;
	way_t                     in_branch_way;
	logic                     commit_wr_en [ways];
	logic [reg_idx_width-1:0] commit_wr_idx [ways];
	logic [xlen-1:0]          commit_wr_data [ways];
	logic [xlen-1:0]          commit_npc [ways];
	logic [1:0]               completed_insts;
	exception_t               error_status;

	int cycle_count  = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	`include "bundle_pipeline_model.svh"

	bundle_pipeline DUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////
	// stimulus helpers
	////////////////////////////////

	function automatic lanes_t random_bundle(bit with_flags);
		lanes_t      lanes;
		logic [31:0] r;
		logic [31:0] base;
		r = next_random();
		base = {r[31:4], 4'h0};
		for (int i = 0; i < ways; i++) begin
			r = next_random();
			lanes[i].valid   = (r[31:30] != 2'b00); // mostly valid
			lanes[i].pc      = base + 32'(i * 4);
			lanes[i].dest    = (r[29:27] == 3'd0) ? zero_reg : r[26:22]; // extra r0 traffic
			lanes[i].result  = next_random();
			lanes[i].halt    = with_flags && (r[21:20] == 2'b00);
			lanes[i].illegal = with_flags && (r[19:18] == 2'b00);
		end
		return lanes;
	endfunction

	task automatic apply_inputs(lanes_t lanes, rollback_t rb, logic take, way_t way);
		for (int i = 0; i < ways; i++) begin
			in_valid[i]   = lanes[i].valid;
			in_pc[i]      = lanes[i].pc;
			in_dest[i]    = lanes[i].dest;
			in_result[i]  = lanes[i].result;
			in_halt[i]    = lanes[i].halt;
			in_illegal[i] = lanes[i].illegal;
		end
		in_rollback      = rb;
		in_take_branch   = take;
		in_branch_target = next_random(); // target never reaches commit
		in_branch_way    = way;
	endtask

	// one bundle per cycle, the bundle from 3 cycles back is checked first
	task automatic run_cycle(lanes_t lanes, rollback_t rb, logic take, way_t way);
		@(negedge clock);
		if (expected_q.size() == 3) compare_commit();
		apply_inputs(lanes, rb, take, way);
		push_expected(lanes, rb, take, way);
	endtask

	task automatic drain();
		repeat (3) run_cycle('0, 2'd0, 1'b0, 2'd0);
	endtask

	task automatic finish_test(string name, int errors_before);
		tests_run++;
		if (check_errors != errors_before) begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, check_errors - errors_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////
	// test sequence
	////////////////////////////////

	initial begin
		int          errors_before;
		logic [31:0] r;
		reset = 1'b0;
		apply_inputs('0, 2'd0, 1'b0, 2'd0);
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;

		// reset quiet, inputs idle and not in the model
		errors_before = check_errors;
		for (int n = 0; n < 3; n++) begin
			if (n > 0) @(negedge clock);
			for (int i = 0; i < ways; i++) begin
				check_value($sformatf("commit_wr_en[%0d]", i), 32'd0, 32'(commit_wr_en[i]));
			end
			check_value("completed_insts", 32'd0, 32'(completed_insts));
			check_value("error_status", 32'(no_error), 32'(error_status));
		end
		finish_test("reset quiet", errors_before);

		errors_before = check_errors;
		repeat (plain_count) run_cycle(random_bundle(1'b0), 2'd0, 1'b0, 2'd0);
		drain();
		finish_test("plain flow", errors_before);

		errors_before = check_errors;
		repeat (rollback_count) begin
			r = next_random();
			run_cycle(random_bundle(1'b0), rollback_t'(r[31:30]), 1'b0, 2'd0);
		end
		drain();
		finish_test("rollback squash", errors_before);

		// about one bundle in four branches
		errors_before = check_errors;
		repeat (branch_count) begin
			r = next_random();
			run_cycle(random_bundle(1'b0), 2'd0, (r[31:30] == 2'b00), way_t'(r[29:16] % 3));
		end
		drain();
		finish_test("branch flush", errors_before);

		errors_before = check_errors;
		repeat (status_count) run_cycle(random_bundle(1'b1), 2'd0, 1'b0, 2'd0);
		drain();
		finish_test("status priority", errors_before);

		$display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
			check_errors);
		if (check_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- bundle_pipeline.f
+incdir+.
pipeline_pkg.sv
bundle_register.sv
pipeline_control.sv
writeback_register.sv
bundle_pipeline.sv
bundle_pipeline_tb.sv

//--- Bender.yml
package:
  name: bundle_pipeline

sources:
  - pipeline_pkg.sv
  - bundle_register.sv
  - pipeline_control.sv
  - writeback_register.sv
  - bundle_pipeline.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - bundle_pipeline_tb.sv
